// File: rtl/ahb_pkg.sv
/*
  AHB-Lite bus types shared by every slave port
  Fixed 32-bit address and 32-bit data bus
  Only single transfers of byte, halfword or word size are served;
  larger HSIZE codes fit the type but the slave does not support them
  HBURST, HPROT and HMASTLOCK are not carried in the request struct
  HRESP is only ever driven OKAY by the slave
*/

package ahb_pkg;

  ////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////

  localparam int HADDR_W = 32;
  localparam int HDATA_W = 32;

  // Byte address on the bus
  typedef logic [HADDR_W-1:0] haddr_t;
  // One data word, read or write
  typedef logic [HDATA_W-1:0] hdata_t;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // Transfer type, as on HTRANS
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_t;

  // Transfer size, as on HSIZE
  // Codes 3'b011 and up are legal bus values but not served
  typedef enum logic [2:0] {
    HSIZE_BYTE  = 3'b000,
    HSIZE_HWORD = 3'b001,
    HSIZE_WORD  = 3'b010
  } hsize_t;

  // Slave response
  typedef enum logic {
    HRESP_OKAY  = 1'b0,
    HRESP_ERROR = 1'b1
  } hresp_t;

  ////////////////////////////////////////////////////////////
  // Per-port bundles
  ////////////////////////////////////////////////////////////

  // Address-phase signals from one master
  typedef struct packed {
    logic    hsel;
    haddr_t  haddr;
    logic    hwrite;
    hsize_t  hsize;
    htrans_t htrans;
    logic    hready;   // bus-level HREADY seen by the slave
  } ahb_req_t;

  // Response of one slave port
  typedef struct packed {
    hdata_t hrdata;
    logic   hreadyout;
    hresp_t hresp;
  } ahb_rsp_t;

endpackage

// File: rtl/sram_pkg.sv
/*
  Storage-side constants and types for the SRAM banks
  A bank word is four byte lanes wide and matches the AHB data bus
  The word index width depends on MEM_DEPTH and is derived per module
*/

package sram_pkg;

  ////////////////////////////////////////////////////////////
  // Word layout
  ////////////////////////////////////////////////////////////

  // Bits per byte lane
  localparam int LANE_W = 8;

  // Byte lanes per word
  localparam int BYTE_LANES = 4;

  // Address bits below the word index
  localparam int WORD_LSB = $clog2(BYTE_LANES);

  // One write enable per byte lane, lane 0 is the LSB
  typedef logic [BYTE_LANES-1:0] byte_en_t;

endpackage

// File: rtl/sram_1r1w.sv
/*
  Generic one-read one-write memory bank, one word per address
  MEM_DEPTH should be a power of two, at least 2
  Read latency is one edge, read-first on a same-edge collision
  The array has no reset, contents are unknown after power-up
  fwd must only be raised in the cycle where we is high
*/

`timescale 1ns/1ps

module sram_1r1w
  import ahb_pkg::*;
  import sram_pkg::*;
#(
  parameter int  MEM_DEPTH = 256,
  localparam int ADDR_W    = $clog2(MEM_DEPTH)
) (
  input  logic              HCLK,
  input  logic              HRESETn,

  // Write side, driven one cycle behind the address phase
  input  logic [ADDR_W-1:0] waddr,
  input  logic              we,
  input  byte_en_t          be,
  input  hdata_t            din,

  // Read side
  input  logic [ADDR_W-1:0] raddr,
  input  logic              fwd,
  output hdata_t            dout
);

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  hdata_t mem [MEM_DEPTH];

  // Registered read word
  hdata_t rd_q;
  // Copy of the last written word, for the forward path
  hdata_t wd_q;
  // Forward select, aligned with rd_q
  logic   fwd_q;

  // Byte-lane write
  always_ff @(posedge HCLK) begin
    if (we) begin
      for (int i = 0; i < BYTE_LANES; i++) begin
        if (be[i]) begin
          mem[waddr][i*LANE_W +: LANE_W] <= din[i*LANE_W +: LANE_W];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////

  // Read every edge; a same-edge write still shows the old word
  always_ff @(posedge HCLK) begin
    rd_q <= mem[raddr];
  end

  // Hold the word being written
  // Only meaningful when all lanes are enabled
  always_ff @(posedge HCLK) begin
    if (we) begin
      wd_q <= din;
    end
  end

  // Models the input register of a real macro
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      fwd_q <= 1'b0;
    end else begin
      fwd_q <= fwd;
    end
  end

  // Written word wins over the stale read
  assign dout = fwd_q ? wd_q : rd_q;

endmodule

// File: rtl/ahb_sram_port.sv
/*
  AHB-Lite slave front end for one private SRAM bank
  Serves single NONSEQ/SEQ transfers of byte, halfword and word size;
  sizes above a word are treated as full-word accesses
  Writes land one edge after the address phase, when HWDATA is valid
  A read right after a partial write to the same word costs one wait state
  Address bits above the bank size are ignored, so the bank aliases
  HRESP is always OKAY
*/

`timescale 1ns/1ps

module ahb_sram_port
  import ahb_pkg::*;
  import sram_pkg::*;
#(
  parameter int  MEM_DEPTH = 256,
  localparam int ADDR_W    = $clog2(MEM_DEPTH)
) (
  input  logic              HCLK,
  input  logic              HRESETn,

  // AHB-Lite side
  input  ahb_req_t          req,
  input  hdata_t            hwdata,
  output ahb_rsp_t          rsp,

  // Bank side
  output logic [ADDR_W-1:0] waddr,
  output logic              we,
  output byte_en_t          be,
  output hdata_t            din,
  output logic [ADDR_W-1:0] raddr,
  output logic              fwd,
  input  hdata_t            dout
);

  ////////////////////////////////////////////////////////////
  // Byte enables
  ////////////////////////////////////////////////////////////

  // Lane mask for the size, moved up to the addressed lane
  function automatic byte_en_t gen_be(input hsize_t size,
                                      input logic [WORD_LSB-1:0] offs);
    byte_en_t lanes;
    case (size)
      HSIZE_BYTE:  lanes = 4'b0001;
      HSIZE_HWORD: lanes = 4'b0011;
      HSIZE_WORD:  lanes = 4'b1111;
      // Wider sizes are not served, take the whole word
      default:     lanes = 4'b1111;
    endcase
    return lanes << offs;
  endfunction

  ////////////////////////////////////////////////////////////
  // Address phase decode
  ////////////////////////////////////////////////////////////

  logic              accept;
  logic              wr_accept;
  logic              rd_accept;
  logic [ADDR_W-1:0] word_idx;

  // Pending write, one cycle behind its address phase
  logic              we_q;
  logic [ADDR_W-1:0] waddr_q;
  byte_en_t          be_q;

  // Contention and response state
  logic              contention;
  logic              full_wr;
  logic              ready_d;
  logic              ready_q;

  // Only active transfers on a ready bus count
  assign accept = req.hsel && req.hready &&
                  (req.htrans == HTRANS_NONSEQ || req.htrans == HTRANS_SEQ);

  assign wr_accept = accept && req.hwrite;
  assign rd_accept = accept && !req.hwrite;

  // Word index inside the bank
  assign word_idx = req.haddr[WORD_LSB +: ADDR_W];

  // Write strobe, cleared on every edge without a write
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      we_q <= 1'b0;
    end else begin
      we_q <= wr_accept;
    end
  end

  // Write target and lanes, held until the next write
  always_ff @(posedge HCLK) begin
    if (wr_accept) begin
      waddr_q <= word_idx;
      be_q    <= gen_be(req.hsize, req.haddr[WORD_LSB-1:0]);
    end
  end

  ////////////////////////////////////////////////////////////
  // Read-after-write contention
  ////////////////////////////////////////////////////////////

  // New read hits the word that lands on this same edge
  assign contention = we_q && rd_accept && (waddr_q == word_idx);

  // All four lanes written
  assign full_wr = &be_q;

  // Full word: bank hands back the written data
  assign fwd = contention && full_wr;

  // Partial word: stall once, bank re-reads after the write
  assign ready_d = !(contention && !full_wr);

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      ready_q <= 1'b1;
    end else begin
      ready_q <= ready_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  assign waddr = waddr_q;
  assign we    = we_q;
  assign be    = be_q;

  // Data phase of the pending write
  assign din   = hwdata;

  // Live address, bank samples it on the accepting edge
  assign raddr = word_idx;

  assign rsp = '{
    hrdata:    dout,
    hreadyout: ready_q,
    hresp:     HRESP_OKAY
  };

endmodule

// File: rtl/mpram_top.sv
/*
  Multi-port SRAM for a RISC-V tile
  One AHB-Lite slave port and one private bank per core
  Banks are not shared, ports run independently of each other
  MEM_DEPTH words per bank, a power of two, at least 2
  Purely structural, no latency beyond the ports themselves
*/

`timescale 1ns/1ps

module mpram_top
  import ahb_pkg::*;
  import sram_pkg::*;
#(
  parameter int  NUM_PORTS = 4,
  parameter int  MEM_DEPTH = 256,
  localparam int ADDR_W    = $clog2(MEM_DEPTH)
) (
  input  logic                     HCLK,
  input  logic                     HRESETn,

  // One AHB-Lite slave per core
  input  ahb_req_t [NUM_PORTS-1:0] req,
  input  hdata_t   [NUM_PORTS-1:0] hwdata,
  output ahb_rsp_t [NUM_PORTS-1:0] rsp
);

  ////////////////////////////////////////////////////////////
  // Port and bank per core
  ////////////////////////////////////////////////////////////

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port

    // Port to bank wiring
    logic [ADDR_W-1:0] waddr;
    logic              we;
    byte_en_t          be;
    hdata_t            din;
    logic [ADDR_W-1:0] raddr;
    logic              fwd;
    hdata_t            dout;

    // Bus decode and contention handling
    ahb_sram_port #(
      .MEM_DEPTH (MEM_DEPTH)
    ) u_port (
      .HCLK    (HCLK),
      .HRESETn (HRESETn),
      .req     (req[p]),
      .hwdata  (hwdata[p]),
      .rsp     (rsp[p]),
      .waddr   (waddr),
      .we      (we),
      .be      (be),
      .din     (din),
      .raddr   (raddr),
      .fwd     (fwd),
      .dout    (dout)
    );

    // Private storage of this core
    sram_1r1w #(
      .MEM_DEPTH (MEM_DEPTH)
    ) u_bank (
      .HCLK    (HCLK),
      .HRESETn (HRESETn),
      .waddr   (waddr),
      .we      (we),
      .be      (be),
      .din     (din),
      .raddr   (raddr),
      .fwd     (fwd),
      .dout    (dout)
    );

  end

endmodule

// File: verification/tb_mpram.sv
/*
  Testbench for the multi-port SRAM, four ports of 256 words each
  Directed table first, then seeded random traffic on all ports at once
  Each master puts an IDLE cycle after a read, so a stalled read keeps
  its own address on the bus; writes are pipelined with the next transfer
  Reads only touch words that were written before
*/

`timescale 1ns/1ps

module tb_mpram
  import ahb_pkg::*;
  import sram_pkg::*;
();

  localparam int NUM_PORTS  = 4;
  localparam int MEM_DEPTH  = 256;
  localparam int IDX_W      = $clog2(MEM_DEPTH);
  localparam int WAIT_LIMIT = 20;
  localparam int RAND_WORDS = 16;
  localparam int RAND_OPS   = 200;
  localparam int MAX_STEPS  = 512;

  // One bus transfer and its expected response
  typedef struct packed {
    int     port;
    logic   wr;
    haddr_t addr;
    hsize_t size;
    hdata_t data;   // write data, or expected read word
    int     waits;  // wait states in the data phase
  } step_t;

  ////////////////////////////////////////////////////////////
  // Directed table, read words are filled in by the model
  ////////////////////////////////////////////////////////////

  localparam int N_DIR = 23;
  localparam step_t DIR_TABLE [N_DIR] = '{
    // Port 0, word writes then reads of other words
    '{0, 1'b1, 32'h00, HSIZE_WORD,  32'h1122_3344, 0},
    '{0, 1'b1, 32'h04, HSIZE_WORD,  32'h5566_7788, 0},
    '{0, 1'b0, 32'h00, HSIZE_WORD,  32'h0,         0},
    '{0, 1'b0, 32'h04, HSIZE_WORD,  32'h0,         0},
    // Port 1, byte and halfword lanes over two base words
    '{1, 1'b1, 32'h10, HSIZE_WORD,  32'hF0F1_F2F3, 0},
    '{1, 1'b1, 32'h14, HSIZE_WORD,  32'hF0F1_F2F3, 0},
    '{1, 1'b1, 32'h10, HSIZE_BYTE,  32'h0000_00B0, 0},
    '{1, 1'b1, 32'h16, HSIZE_BYTE,  32'h00D2_0000, 0},
    '{1, 1'b1, 32'h11, HSIZE_BYTE,  32'h0000_C100, 0},
    '{1, 1'b1, 32'h17, HSIZE_BYTE,  32'hE300_0000, 0},
    '{1, 1'b1, 32'h12, HSIZE_HWORD, 32'hCAFE_0000, 0},
    '{1, 1'b1, 32'h14, HSIZE_HWORD, 32'h0000_BEEF, 0},
    '{1, 1'b0, 32'h10, HSIZE_WORD,  32'h0,         0},
    '{1, 1'b0, 32'h14, HSIZE_WORD,  32'h0,         0},
    // Port 2, full word forwarded to the next read
    '{2, 1'b1, 32'h40, HSIZE_WORD,  32'hDEAD_BEEF, 0},
    '{2, 1'b0, 32'h40, HSIZE_WORD,  32'h0,         0},
    '{2, 1'b1, 32'h40, HSIZE_WORD,  32'h0BAD_F00D, 0},
    '{2, 1'b0, 32'h41, HSIZE_BYTE,  32'h0,         0},
    // Port 3, partial write then read costs one wait
    '{3, 1'b1, 32'h80, HSIZE_WORD,  32'h0000_0000, 0},
    '{3, 1'b1, 32'h82, HSIZE_BYTE,  32'h0055_0000, 0},
    '{3, 1'b0, 32'h80, HSIZE_WORD,  32'h0,         1},
    '{3, 1'b1, 32'h80, HSIZE_HWORD, 32'h0000_ABCD, 0},
    '{3, 1'b0, 32'h81, HSIZE_BYTE,  32'h0,         1}
  };

  logic                     HCLK;
  logic                     HRESETn;
  ahb_req_t [NUM_PORTS-1:0] req_bus;
  hdata_t   [NUM_PORTS-1:0] hwdata_bus;
  ahb_rsp_t [NUM_PORTS-1:0] rsp;
  ahb_req_t                 req_drv [NUM_PORTS];
  hdata_t                   wdata_drv [NUM_PORTS];

  step_t       steps [MAX_STEPS];
  int          n_steps;
  hdata_t      model_mem [NUM_PORTS][MEM_DEPTH];
  int          errors;
  int          timeouts;
  logic [31:0] rng;

  mpram_top #(
    .NUM_PORTS (NUM_PORTS),
    .MEM_DEPTH (MEM_DEPTH)
  ) u_dut (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .req     (req_bus),
    .hwdata  (hwdata_bus),
    .rsp     (rsp)
  );

  // Single slave per bus, hreadyout comes back as hready
  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      req_bus[p]        = req_drv[p];
      req_bus[p].hready = rsp[p].hreadyout;
      hwdata_bus[p]     = wdata_drv[p];
    end
  end

  initial begin
    HCLK = 1'b0;
    forever #20 HCLK = ~HCLK;
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int word_of(input haddr_t a);
    return int'(a[WORD_LSB +: IDX_W]);
  endfunction

  // Size mask moved up by the low address bits
  function automatic byte_en_t lane_mask(input hsize_t size, input haddr_t a);
    byte_en_t base;
    case (size)
      HSIZE_BYTE:  base = 4'b0001;
      HSIZE_HWORD: base = 4'b0011;
      default:     base = 4'b1111;
    endcase
    return base << a[WORD_LSB-1:0];
  endfunction

  function automatic hdata_t merge_word(input hdata_t old_w, input hdata_t new_w,
                                        input byte_en_t m);
    hdata_t r;
    r = old_w;
    for (int i = 0; i < BYTE_LANES; i++) begin
      if (m[i]) begin
        r[i*LANE_W +: LANE_W] = new_w[i*LANE_W +: LANE_W];
      end
    end
    return r;
  endfunction

  // Walk the steps in order, fill expected read words and optionally waits
  task automatic predict_steps(input int lo, input int hi, input bit calc_waits);
    bit       last_wr [NUM_PORTS];
    int       last_w [NUM_PORTS];
    byte_en_t last_m [NUM_PORTS];
    int       p;
    int       w;
    byte_en_t m;
    for (int q = 0; q < NUM_PORTS; q++) begin
      last_wr[q] = 1'b0;
    end
    for (int j = lo; j < hi; j++) begin
      p = steps[j].port;
      w = word_of(steps[j].addr);
      m = lane_mask(steps[j].size, steps[j].addr);
      if (steps[j].wr) begin
        model_mem[p][w] = merge_word(model_mem[p][w], steps[j].data, m);
        last_wr[p] = 1'b1;
        last_w[p]  = w;
        last_m[p]  = m;
      end else begin
        steps[j].data = model_mem[p][w];
        // Stall only right behind a partial write to the same word
        if (calc_waits) begin
          steps[j].waits = (last_wr[p] && last_w[p] == w && last_m[p] != 4'hF) ? 1 : 0;
        end
        last_wr[p] = 1'b0;
      end
    end
  endtask

  task automatic add_step(input int p, input logic wr, input haddr_t a,
                          input hsize_t s, input hdata_t d);
    steps[n_steps] = '{p, wr, a, s, d, 0};
    n_steps++;
  endtask

  // Preload, random mix over the same few words on every port, readback
  task automatic gen_random();
    logic [31:0] r;
    int          p;
    int          w;
    int          off;
    logic        wr;
    hsize_t      sz;
    bit          last_wr [NUM_PORTS];
    int          last_w [NUM_PORTS];
    rng = 32'd84;
    for (int q = 0; q < NUM_PORTS; q++) begin
      last_wr[q] = 1'b0;
      last_w[q]  = 0;
      for (int k = 0; k < RAND_WORDS; k++) begin
        rng = xorshift32(rng);
        add_step(q, 1'b1, haddr_t'(k * BYTE_LANES), HSIZE_WORD, rng);
      end
    end
    for (int k = 0; k < RAND_OPS; k++) begin
      rng = xorshift32(rng);
      r   = rng;
      p   = int'(r[1:0]);
      w   = int'(r[5:2]);
      wr  = r[6];
      // Often read back the word just written
      if (r[7] && last_wr[p]) begin
        wr = 1'b0;
        w  = last_w[p];
      end
      case (r[9:8])
        2'd0:    sz = HSIZE_BYTE;
        2'd1:    sz = HSIZE_HWORD;
        default: sz = HSIZE_WORD;
      endcase
      // Aligned lane offset
      off = (sz == HSIZE_BYTE) ? int'(r[11:10]) : (sz == HSIZE_HWORD) ? int'(r[11]) * 2 : 0;
      rng = xorshift32(rng);
      add_step(p, wr, haddr_t'(w * BYTE_LANES + off), sz, rng);
      last_wr[p] = wr;
      last_w[p]  = w;
    end
    for (int q = 0; q < NUM_PORTS; q++) begin
      for (int k = 0; k < RAND_WORDS; k++) begin
        add_step(q, 1'b0, haddr_t'(k * BYTE_LANES), HSIZE_WORD, '0);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Bus master per port
  ////////////////////////////////////////////////////////////

  task automatic check_step(input int j, input int waits);
    int p;
    p = steps[j].port;
    if (waits != steps[j].waits) begin
      $display("ERR %0t rsp[%0d].hreadyout wait states expected %0d actual %0d",
               $time, p, steps[j].waits, waits);
      errors++;
    end
    if (rsp[p].hresp !== HRESP_OKAY) begin
      $display("ERR %0t rsp[%0d].hresp expected %0d actual %0d",
               $time, p, HRESP_OKAY, rsp[p].hresp);
      errors++;
    end
    if (!steps[j].wr && rsp[p].hrdata !== steps[j].data) begin
      $display("ERR %0t rsp[%0d].hrdata expected %08h actual %08h",
               $time, p, steps[j].data, rsp[p].hrdata);
      errors++;
    end
  endtask

  // Address phase of step i overlaps the data phase of step cur
  task automatic run_port(input int p, input int lo, input int hi);
    int       ids [$];
    int       i;
    int       cur;
    int       nxt;
    int       waits;
    ahb_req_t a;
    for (int j = lo; j < hi; j++) begin
      if (steps[j].port == p) begin
        ids.push_back(j);
      end
    end
    i   = 0;
    cur = -1;
    @(posedge HCLK);
    while (i < ids.size() || cur >= 0) begin
      nxt = -1;
      a   = req_drv[p];
      // No new transfer behind a read, the address stays put
      if (i < ids.size() && (cur < 0 || steps[cur].wr)) begin
        nxt      = ids[i];
        i++;
        a.hsel   = 1'b1;
        a.haddr  = steps[nxt].addr;
        a.hwrite = steps[nxt].wr;
        a.hsize  = steps[nxt].size;
        a.htrans = HTRANS_NONSEQ;
      end else begin
        a.hsel   = 1'b0;
        a.htrans = HTRANS_IDLE;
      end
      req_drv[p] <= a;
      if (cur >= 0 && steps[cur].wr) begin
        wdata_drv[p] <= steps[cur].data;
      end
      // hreadyout is registered, stable at the falling edge
      waits = 0;
      @(negedge HCLK);
      while (!rsp[p].hreadyout) begin
        waits++;
        if (waits > WAIT_LIMIT) begin
          $display("Timeout on port %0d, hreadyout stayed low for %0d cycles", p, waits);
          timeouts++;
          return;
        end
        @(negedge HCLK);
      end
      if (cur >= 0) begin
        check_step(cur, waits);
      end
      @(posedge HCLK);
      cur = nxt;
    end
  endtask

  task automatic run_phase(input int lo, input int hi);
    fork
      run_port(0, lo, hi);
      run_port(1, lo, hi);
      run_port(2, lo, hi);
      run_port(3, lo, hi);
    join
  endtask

  initial begin
    errors   = 0;
    timeouts = 0;
    n_steps  = 0;
    HRESETn  = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      req_drv[p]   = '{hsel: 1'b0, haddr: '0, hwrite: 1'b0, hsize: HSIZE_WORD,
                       htrans: HTRANS_IDLE, hready: 1'b1};
      wdata_drv[p] = '0;
    end
    repeat (10) @(posedge HCLK);
    HRESETn <= 1'b1;

    // Idle response out of reset
    @(negedge HCLK);
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (rsp[p].hreadyout !== 1'b1 || rsp[p].hresp !== HRESP_OKAY) begin
        $display("ERR %0t rsp[%0d] hreadyout/hresp expected 1/0 actual %0b/%0b",
                 $time, p, rsp[p].hreadyout, rsp[p].hresp);
        errors++;
      end
    end

    for (int j = 0; j < N_DIR; j++) begin
      steps[j] = DIR_TABLE[j];
    end
    n_steps = N_DIR;
    predict_steps(0, N_DIR, 1'b0);
    run_phase(0, N_DIR);

    gen_random();
    predict_steps(N_DIR, n_steps, 1'b1);
    run_phase(N_DIR, n_steps);

    $display("Closing summary: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: sim.f
rtl/ahb_pkg.sv
rtl/sram_pkg.sv
rtl/sram_1r1w.sv
rtl/ahb_sram_port.sv
rtl/mpram_top.sv
verification/tb_mpram.sv

// File: Makefile
# Verilator flow for the multi-port SRAM testbench

VERILATOR  := verilator
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
TOP        := tb_mpram
FILELIST   := sim.f
OBJ_DIR    := obj_dir
PASS_MSG   := Regression passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message appears on a line of its own
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
